// ==== allocator/lbuf_alloc_walk.sv ====
// Allocation walker of the local buffer
// Steps through a requested range of table ids, reserving one block per id
// at the ring cursor and pushing it to the release queue
// Keeps the ring cursor and the free capacity, frees add space back
`timescale 1ns/100ps

module lbuf_alloc_walk (
	input  logic                                          i_clk,
	input  logic                                          i_arst_n,
	input  lbuf_pkg::lbuf_size_t [lbuf_pkg::N_ICFG-1:0]  i_sizes,
	// Allocation request
	input  logic                                          i_alloc_rdy,
	output logic                                          o_alloc_ack,
	input  logic [lbuf_pkg::ICFG_BW-1:0]                  i_beg_id,
	input  logic [lbuf_pkg::ICFG_BW-1:0]                  i_end_id,
	// Push side of the release queue
	output logic                                          o_q_rdy,
	input  logic                                          i_q_ack,
	output lbuf_pkg::lbuf_entry_t                         o_q_entry,
	input  logic                                          i_q_pop,
	// Free a table entry
	input  logic                                          i_free_dval,
	input  logic [lbuf_pkg::ICFG_BW-1:0]                  i_free_id
);

	import lbuf_pkg::*;

	walk_state_e        state_r;
	walk_state_e        state_w;

	// Id being walked
	logic [ICFG_BW-1:0] id_r;
	logic [ICFG_BW-1:0] id_w;
	logic [ICFG_BW-1:0] id_nxt;
	logic               last;

	// Ring cursor and free capacity in vectors
	lbuf_hi_t           cur_r;
	lbuf_size_t         cap_r;
	lbuf_size_t         cap_w;

	// Own copy of queue occupancy
	logic [QCNT_BW-1:0] qcnt_r;

	lbuf_size_t         cur_size;
	lbuf_size_t         free_size;
	logic               has_space;
	logic               has_room;
	logic               push;

	// ================================================
	// Push condition
	// ================================================

	always_comb begin
		cur_size  = i_sizes[id_r[IDX_BW-1:0]];
		// Size of the freed entry as it reads right now
		free_size = i_sizes[i_free_id[IDX_BW-1:0]];
		id_nxt    = id_r + 1'b1;
		// End id is held stable by the requester until ack
		last      = id_nxt == i_end_id;
		has_space = cap_r >= cur_size;
		has_room  = qcnt_r < QCNT_BW'(QDEPTH);
		// Stalls on capacity or a full queue
		o_q_rdy   = (state_r == WALK_BUSY) && has_space && has_room;
		push      = o_q_rdy && i_q_ack;
		// Request done with its last push
		o_alloc_ack = push && last;
	end

	// Block reserved at the current cursor
	always_comb begin
		o_q_entry.hi   = cur_r;
		o_q_entry.size = cur_size;
	end

	// ================================================
	// Walker FSM
	// ================================================

	always_comb begin
		state_w = state_r;
		id_w    = id_r;
		case (state_r)
			WALK_IDLE: begin
				if (i_alloc_rdy) begin
					state_w = WALK_BUSY;
					id_w    = i_beg_id;
				end
			end
			WALK_BUSY: begin
				if (push) begin
					id_w = id_nxt;
					if (last) begin
						state_w = WALK_IDLE;
					end
				end
			end
			default: state_w = WALK_IDLE;
		endcase
	end

	// Capacity, push and free may hit together
	always_comb begin
		cap_w = cap_r;
		if (push) begin
			cap_w = cap_w - cur_size;
		end
		if (i_free_dval) begin
			cap_w = cap_w + free_size;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_r <= WALK_IDLE;
			id_r    <= '0;
			cur_r   <= '0;
			cap_r   <= CAPACITY;
			qcnt_r  <= '0;
		end else begin
			state_r <= state_w;
			id_r    <= id_w;
			cap_r   <= cap_w;
			// Cursor wraps at the ring size
			if (push) begin
				cur_r <= cur_r + cur_size[HBW-1:0];
			end
			case ({push, i_q_pop})
				2'b10:   qcnt_r <= qcnt_r + 1'b1;
				2'b01:   qcnt_r <= qcnt_r - 1'b1;
				default: qcnt_r <= qcnt_r;
			endcase
		end
	end

	// Frees never return more than was taken
	a_cap_bound: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		cap_r <= CAPACITY
	) else $error("Capacity above ring size");

	// Push request held until the queue takes it
	a_q_hold: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_q_rdy && !i_q_ack |=> o_q_rdy
	) else $error("Queue push dropped before ack");

endmodule

// ==== allocator/lbuf_release_queue.sv ====
// Release queue of reserved blocks
// Counts DMA vector writes and offers the head block's word address
// only once the whole head block is written
// Not empty doubles as the notice to the DMA that work is waiting
`timescale 1ns/100ps

module lbuf_release_queue (
	input  logic                          i_clk,
	input  logic                          i_arst_n,
	// Push from the walker
	input  logic                          i_q_rdy,
	output logic                          o_q_ack,
	input  lbuf_pkg::lbuf_entry_t         i_q_entry,
	output logic                          o_q_pop,
	// Notice to the DMA
	output logic                          o_allocated_rdy,
	input  logic                          i_allocated_ack,
	// DMA vector write strobe
	input  logic                          i_we_dval,
	// Released address
	output logic                          o_linear_rdy,
	input  logic                          i_linear_ack,
	output logic [lbuf_pkg::LBW-1:0]      o_linear
);

	import lbuf_pkg::*;

	// Entry storage
	lbuf_entry_t        mem [QDEPTH];

	logic [QPTR_BW-1:0] wr_ptr_r;
	logic [QPTR_BW-1:0] rd_ptr_r;
	logic [QCNT_BW-1:0] cnt_r;

	// Vectors written but not yet released
	lbuf_size_t         fill_r;
	lbuf_size_t         fill_w;

	lbuf_entry_t        head;
	logic               empty;
	logic               full;
	logic               push;
	logic               pop;

	// Pointer step with wrap at the queue depth
	function automatic logic [QPTR_BW-1:0] ptr_inc(input logic [QPTR_BW-1:0] p);
		logic [QPTR_BW-1:0] n;
		n = (p == QPTR_BW'(QDEPTH - 1)) ? '0 : p + 1'b1;
		return n;
	endfunction

	// ================================================
	// Handshakes
	// ================================================

	always_comb begin
		empty   = cnt_r == '0;
		full    = cnt_r == QCNT_BW'(QDEPTH);
		// Accept whenever there is a free slot
		o_q_ack = i_q_rdy && !full;
		push    = o_q_ack;
		head    = mem[rd_ptr_r];
		// Head goes out only when fully written
		o_linear_rdy = !empty && (fill_r >= head.size);
		pop     = o_linear_rdy && i_linear_ack;
		o_q_pop = pop;
		o_allocated_rdy = !empty;
	end

	// Head vector index as a word address
	assign o_linear = {head.hi, {CV_BW{1'b0}}};

	// ================================================
	// Storage and pointers
	// ================================================

	always_ff @(posedge i_clk) begin
		if (push) begin
			mem[wr_ptr_r] <= i_q_entry;
		end
	end

	// Fill count, a write and a release may hit together
	always_comb begin
		fill_w = fill_r;
		if (i_we_dval) begin
			fill_w = fill_w + 1'b1;
		end
		if (pop) begin
			fill_w = fill_w - head.size;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			cnt_r    <= '0;
			fill_r   <= '0;
		end else begin
			fill_r <= fill_w;
			if (push) begin
				wr_ptr_r <= ptr_inc(wr_ptr_r);
			end
			if (pop) begin
				rd_ptr_r <= ptr_inc(rd_ptr_r);
			end
			case ({push, pop})
				2'b10:   cnt_r <= cnt_r + 1'b1;
				2'b01:   cnt_r <= cnt_r - 1'b1;
				default: cnt_r <= cnt_r;
			endcase
		end
	end

	// Release taken only when offered
	a_linear_ack: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		i_linear_ack |-> o_linear_rdy
	) else $error("Linear ack without linear rdy");

	// DMA notice only acknowledged while blocks are waiting
	a_allocated_ack: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		i_allocated_ack |-> o_allocated_rdy
	) else $error("Allocated ack with empty queue");

endmodule

// ==== common/lbuf_pkg.sv ====
// Shared definitions for the local buffer space manager
// Geometry of the ring buffer, size table and release queue
// Modules import this package inside their bodies
package lbuf_pkg;

	// ================================================
	// Buffer geometry
	// ================================================

	// Word address width of the local buffer
	localparam int LBW = 10;
	// Word bits inside one vector of 16 words
	localparam int CV_BW = 4;
	// Vector index width
	localparam int HBW = LBW - CV_BW;
	// Ring size in vectors, one bit wider than an index
	localparam logic [HBW:0] CAPACITY = 1 << HBW;

	// ================================================
	// Size table and release queue
	// ================================================

	// Number of size table entries
	localparam int N_ICFG = 4;
	// Id width, wide enough to hold N_ICFG as an exclusive end
	localparam int ICFG_BW = $clog2(N_ICFG + 1);
	// Index width into the table itself
	localparam int IDX_BW = $clog2(N_ICFG);

	// Release queue depth
	localparam int QDEPTH = 5;
	// Queue pointer width
	localparam int QPTR_BW = $clog2(QDEPTH);
	// Occupancy counter width, counts 0 up to QDEPTH
	localparam int QCNT_BW = $clog2(QDEPTH + 1);

	// ================================================
	// Types
	// ================================================

	// Block size in vectors, up to the full ring
	typedef logic [HBW:0] lbuf_size_t;

	// Ring vector index
	typedef logic [HBW-1:0] lbuf_hi_t;

	// One reserved block waiting in the release queue
	typedef struct packed {
		lbuf_hi_t   hi;
		lbuf_size_t size;
	} lbuf_entry_t;

	// Allocation walker states
	typedef enum logic {
		WALK_IDLE = 1'b0,
		WALK_BUSY = 1'b1
	} walk_state_e;

endpackage

// ==== dv/lbuf_stim.txt ====
// Four hex fields per record: opcode arg_a arg_b expected
// 1 APB write addr data, 2 APB read addr exp, 3 allocate beg end, 4 write pulses count
// 5 take linear exp_addr, 6 free id, 7 random delay flag on/off, 0 ends the list
// Size table, then read back and holes past the table
1 0 5 0
1 1 c 0
1 2 14 0
1 3 9 0
1 5 3f 0
2 0 0 5
2 1 0 c
2 2 0 14
2 3 0 9
2 5 0 0
2 9 0 0
// Four blocks from ids 0 to 4, released after enough writes
3 0 4 0
4 4 0 0
4 1 0 0
5 0 0 0
4 c 0 0
5 0 0 50
4 14 0 0
5 0 0 110
4 9 0 0
5 0 0 250
// Capacity stall until frees return space, ring wraps past 64
3 1 3 0
6 0 0 0
6 1 0 0
3 3 4 0
6 2 0 0
// Linear side held back for random delays
7 1 0 0
4 c 0 0
5 0 0 2e0
4 14 0 0
5 0 0 3a0
4 9 0 0
5 0 0 e0
// One-vector blocks until the queue is full
6 3 0 0
1 0 1 0
3 0 1 0
3 0 1 0
3 0 1 0
3 0 1 0
3 0 1 0
3 0 1 0
4 1 0 0
5 0 0 170
4 5 0 0
5 0 0 180
5 0 0 190
5 0 0 1a0
5 0 0 1b0
5 0 0 1c0
0 0 0 0

// ==== dv/tb_lbuf.sv ====
// Testbench of the local buffer space manager
// Reads op records from dv/lbuf_stim.txt and drives APB, allocation requests,
// DMA write strobes, releases and frees into lbuf_top
// A ring model of cursor, capacity, fill count and queued blocks gives the expected values
`timescale 1ns/100ps

module tb_lbuf;

	import lbuf_pkg::*;

	localparam int MAX_REC    = 64;
	localparam int ACK_WAIT   = 40;
	localparam int STALL_WAIT = 20;

	logic                i_clk;
	logic                i_arst_n;
	logic                i_psel;
	logic                i_penable;
	logic                i_pwrite;
	logic [3:0]          i_paddr;
	logic [31:0]         i_pwdata;
	logic [31:0]         o_prdata;
	logic                o_pready;
	logic                i_alloc_rdy;
	logic                o_alloc_ack;
	logic [ICFG_BW-1:0]  i_beg_id;
	logic [ICFG_BW-1:0]  i_end_id;
	logic                o_allocated_rdy;
	logic                i_allocated_ack;
	logic                i_we_dval;
	logic                o_linear_rdy;
	logic                i_linear_ack;
	logic [LBW-1:0]      o_linear;
	logic                i_free_dval;
	logic [ICFG_BW-1:0]  i_free_id;

	// Four hex fields per record as opcode, arg a, arg b and expected value
	logic [15:0]         stim_mem [0:4*MAX_REC-1];
	int                  nrec;
	bit                  loaded;

	// Ring model
	int                  mtab [N_ICFG];
	int                  mcap;
	int                  mcur;
	int                  mfill;
	int                  exp_addr_q [$];
	int                  exp_size_q [$];
	// Request still walking in the model
	bit                  pend_active;
	int                  pend_id;
	int                  pend_end;

	bit                  rand_mode;
	integer              seed;
	int                  err_cnt;

	lbuf_top dut0 (.*);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	// ================================================
	// Reporting and model
	// ================================================

	task automatic value_error(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic protocol_failure(input string msg);
		$display("Problem at %0t ns: %s", $time, msg);
		err_cnt++;
	endtask

	// Reserve blocks id by id while capacity and queue room allow
	// Returns 1 once the whole pending range has been reserved
	function automatic bit advance_model();
		int  sz;
		bit  stalled;
		stalled = 1'b0;
		while (pend_active && pend_id < pend_end && !stalled) begin
			sz = mtab[pend_id];
			if (mcap < sz || exp_addr_q.size() >= QDEPTH) begin
				stalled = 1'b1;
			end else begin
				exp_addr_q.push_back(mcur * (1 << CV_BW));
				exp_size_q.push_back(sz);
				mcap = mcap - sz;
				mcur = (mcur + sz) % int'(CAPACITY);
				pend_id++;
			end
		end
		return pend_active && pend_id == pend_end;
	endfunction

	function automatic string op_name(input int op);
		case (op)
			1: return "APB write";
			2: return "APB read";
			3: return "allocate";
			4: return "write pulses";
			5: return "take linear";
			6: return "free";
			7: return "random delay flag";
			default: return "unknown";
		endcase
	endfunction

	// ================================================
	// Bus and handshake tasks that start and end at a falling edge
	// ================================================

	task automatic apb_write(input int addr, input int data);
		i_psel    = 1'b1;
		i_pwrite  = 1'b1;
		i_paddr   = 4'(addr);
		i_pwdata  = 32'(data);
		i_penable = 1'b0;
		@(negedge i_clk);
		i_penable = 1'b1;
		@(negedge i_clk);
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
		if (addr < N_ICFG) begin
			mtab[addr] = data & ((1 << (HBW + 1)) - 1);
		end
	endtask

	task automatic apb_read(input int addr, output logic [31:0] data, output logic rdy);
		i_psel    = 1'b1;
		i_pwrite  = 1'b0;
		i_paddr   = 4'(addr);
		i_penable = 1'b0;
		@(negedge i_clk);
		i_penable = 1'b1;
		@(negedge i_clk);
		// Read data is settled while the access phase is still held
		data      = o_prdata;
		rdy       = o_pready;
		i_psel    = 1'b0;
		i_penable = 1'b0;
	endtask

	// The ack may already be up at this edge so sample first
	task automatic wait_alloc_ack();
		int n;
		bit seen;
		n    = 0;
		seen = o_alloc_ack;
		while (!seen && n < ACK_WAIT) begin
			@(negedge i_clk);
			seen = o_alloc_ack;
			n++;
		end
		if (!seen) begin
			protocol_failure($sformatf("no o_alloc_ack within %0d cycles", ACK_WAIT));
		end else begin
			// Transfer on the rising edge in between
			@(negedge i_clk);
			if (o_alloc_ack) begin
				value_error("o_alloc_ack high for more than one cycle");
			end
		end
		i_alloc_rdy = 1'b0;
		pend_active = 1'b0;
	endtask

	task automatic settle_request();
		if (advance_model()) begin
			wait_alloc_ack();
		end
	endtask

	task automatic request_alloc(input int beg_id, input int end_id);
		i_beg_id    = ICFG_BW'(beg_id);
		i_end_id    = ICFG_BW'(end_id);
		i_alloc_rdy = 1'b1;
		pend_active = 1'b1;
		pend_id     = beg_id;
		pend_end    = end_id;
		if (advance_model()) begin
			wait_alloc_ack();
		end else begin
			// Request stays up on a stalled walker until space returns
			repeat (STALL_WAIT) begin
				@(negedge i_clk);
				if (o_alloc_ack) begin
					value_error("o_alloc_ack while the request cannot fit");
				end
			end
		end
	endtask

	task automatic write_pulses(input int count);
		bit exp_rdy;
		repeat (count) begin
			i_we_dval = 1'b1;
			@(negedge i_clk);
			mfill++;
			exp_rdy = (exp_size_q.size() > 0) && (mfill >= exp_size_q[0]);
			if (o_linear_rdy !== exp_rdy) begin
				value_error($sformatf("o_linear_rdy %0b after fill %0d, expected %0b",
					o_linear_rdy, mfill, exp_rdy));
			end
			if (o_allocated_rdy !== (exp_addr_q.size() > 0)) begin
				value_error($sformatf("o_allocated_rdy %0b with %0d blocks queued",
					o_allocated_rdy, exp_addr_q.size()));
			end
		end
		i_we_dval = 1'b0;
	endtask

	task automatic take_linear(input int exp);
		int             n;
		int             delay;
		logic [LBW-1:0] held;
		n = 0;
		while (!o_linear_rdy && n < ACK_WAIT) begin
			@(negedge i_clk);
			n++;
		end
		if (!o_linear_rdy) begin
			protocol_failure("o_linear_rdy never rose for a take");
		end else if (exp_addr_q.size() == 0) begin
			protocol_failure("DUT offered an address with no block reserved");
		end else begin
			held  = o_linear;
			delay = rand_mode ? ($random(seed) & 7) : 0;
			// DMA notice alone leaves the queue as it is
			i_allocated_ack = 1'b1;
			@(negedge i_clk);
			i_allocated_ack = 1'b0;
			if (o_allocated_rdy !== 1'b1 || o_linear_rdy !== 1'b1 || o_linear !== held) begin
				value_error($sformatf("allocated ack moved the head, o_linear 0x%0h rdy %0b %0b",
					o_linear, o_linear_rdy, o_allocated_rdy));
			end
			// DMA keeps writing while the release is held back
			repeat (delay) begin
				i_we_dval = 1'b1;
				@(negedge i_clk);
				mfill++;
				if (o_linear_rdy !== 1'b1 || o_linear !== held) begin
					value_error($sformatf("o_linear 0x%0h rdy %0b while holding 0x%0h",
						o_linear, o_linear_rdy, held));
				end
			end
			i_we_dval = 1'b0;
			if (exp != exp_addr_q[0]) begin
				protocol_failure($sformatf("stim address 0x%0h differs from model 0x%0h",
					exp, exp_addr_q[0]));
			end
			if (held !== LBW'(exp_addr_q[0])) begin
				value_error($sformatf("o_linear 0x%0h, expected 0x%0h", held, exp_addr_q[0]));
			end
			mfill = mfill - exp_size_q[0];
			n = exp_addr_q.pop_front();
			n = exp_size_q.pop_front();
			i_linear_ack = 1'b1;
			@(negedge i_clk);
			i_linear_ack = 1'b0;
			if (o_allocated_rdy !== (exp_addr_q.size() > 0)) begin
				value_error($sformatf("o_allocated_rdy %0b after release, %0d blocks left",
					o_allocated_rdy, exp_addr_q.size()));
			end
			// A freed queue slot may let a stalled request go on
			settle_request();
		end
	endtask

	task automatic free_entry(input int id);
		i_free_id   = ICFG_BW'(id);
		i_free_dval = 1'b1;
		mcap        = mcap + mtab[id];
		@(negedge i_clk);
		i_free_dval = 1'b0;
		settle_request();
	endtask

	// ================================================
	// Watchdog
	// ================================================

	initial begin
		wait (loaded);
		repeat (nrec * 200 + 10) @(posedge i_clk);
		$display("Timeout: the run took more than %0d clock cycles", nrec * 200 + 10);
		$display("Finished with errors");
		$finish;
	end

	// ================================================
	// Record loop
	// ================================================

	initial begin
		int          op;
		int          arg_a;
		int          arg_b;
		int          exp;
		int          errs_before;
		int          npass;
		logic [31:0] rdata;
		logic        rdy;
		{i_arst_n, i_psel, i_penable, i_pwrite, i_alloc_rdy} = '0;
		{i_allocated_ack, i_we_dval, i_linear_ack, i_free_dval} = '0;
		i_paddr   = '0;
		i_pwdata  = '0;
		i_beg_id  = '0;
		i_end_id  = '0;
		i_free_id = '0;
		seed      = 32'hb158bab3;
		err_cnt   = 0;
		npass     = 0;
		rand_mode = 1'b0;
		pend_active = 1'b0;
		mcap      = int'(CAPACITY);
		mcur      = 0;
		mfill     = 0;
		for (int i = 0; i < N_ICFG; i++) begin
			mtab[i] = 0;
		end
		for (int i = 0; i < 4 * MAX_REC; i++) begin
			stim_mem[i] = '0;
		end
		$readmemh("dv/lbuf_stim.txt", stim_mem);
		nrec = 0;
		while (nrec < MAX_REC && stim_mem[4 * nrec] != 0) begin
			nrec++;
		end
		loaded = 1'b1;

		// Reset held for two cycles and released on a falling edge
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_arst_n = 1'b1;
		errs_before = err_cnt;
		if (o_alloc_ack !== 1'b0 || o_allocated_rdy !== 1'b0 || o_linear_rdy !== 1'b0) begin
			value_error("handshake outputs not low after reset");
		end
		$display("Reset state: %s", (err_cnt == errs_before) ? "passed" : "failed");

		for (int r = 0; r < nrec; r++) begin
			op          = stim_mem[4 * r];
			arg_a       = stim_mem[4 * r + 1];
			arg_b       = stim_mem[4 * r + 2];
			exp         = stim_mem[4 * r + 3];
			errs_before = err_cnt;
			case (op)
				1: apb_write(arg_a, arg_b);
				2: begin
					apb_read(arg_a, rdata, rdy);
					n_check_read: begin
						int model_val;
						model_val = (arg_a < N_ICFG) ? mtab[arg_a] : 0;
						if (exp != model_val) begin
							protocol_failure("stim read value differs from the table model");
						end
						if (rdata !== 32'(model_val) || rdy !== 1'b1) begin
							value_error($sformatf("APB read 0x%0h gave 0x%0h ready %0b, expected 0x%0h",
								arg_a, rdata, rdy, model_val));
						end
					end
				end
				3: request_alloc(arg_a, arg_b);
				4: write_pulses(arg_a);
				5: take_linear(exp);
				6: free_entry(arg_a);
				7: rand_mode = (arg_a != 0);
				default: protocol_failure($sformatf("unknown opcode %0d in record %0d", op, r));
			endcase
			if (err_cnt == errs_before) begin
				npass++;
			end
			$display("Record %0d %s: %s", r, op_name(op),
				(err_cnt == errs_before) ? "passed" : "failed");
		end

		$display("%0d records run, %0d passed, %0d errors", nrec, npass, err_cnt);
		if (err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
common/lbuf_pkg.sv
logic/lbuf_size_table.sv
allocator/lbuf_alloc_walk.sv
allocator/lbuf_release_queue.sv
logic/lbuf_top.sv
dv/tb_lbuf.sv

// ==== logic/lbuf_size_table.sv ====
// APB register file of per-entry block sizes
// Software writes one size in vectors per table entry
// The whole table is driven out to the allocation walker
`timescale 1ns/100ps

module lbuf_size_table (
	input  logic                                          i_clk,
	input  logic                                          i_arst_n,
	// APB slave
	input  logic                                          i_psel,
	input  logic                                          i_penable,
	input  logic                                          i_pwrite,
	input  logic [3:0]                                    i_paddr,
	input  logic [31:0]                                   i_pwdata,
	output logic [31:0]                                   o_prdata,
	output logic                                          o_pready,
	// Table contents to the walker
	output lbuf_pkg::lbuf_size_t [lbuf_pkg::N_ICFG-1:0]  o_sizes
);

	import lbuf_pkg::*;

	// Size registers, one per table entry
	lbuf_size_t [N_ICFG-1:0] size_r;

	// Decoded access
	logic              in_range;
	logic              wr_en;
	logic [IDX_BW-1:0] idx;

	// ================================================
	// Address decode
	// ================================================

	always_comb begin
		// Word address k selects entry k, anything past the table is a hole
		in_range = i_paddr < 4'(N_ICFG);
		idx      = i_paddr[IDX_BW-1:0];
		// Write lands at the end of the access phase
		wr_en    = i_psel && i_penable && i_pwrite && in_range;
	end

	// ================================================
	// Register file
	// ================================================

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			size_r <= '0;
		end else if (wr_en) begin
			// Only the size bits are kept
			size_r[idx] <= i_pwdata[HBW:0];
		end
	end

	// Read data, zero-extended, holes read zero
	always_comb begin
		o_prdata = in_range ? 32'(size_r[idx]) : 32'd0;
	end

	// No wait states
	assign o_pready = 1'b1;

	// Whole table to the walker
	assign o_sizes = size_r;

	// Access phase always follows a select
	a_penable_psel: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		i_penable |-> i_psel
	) else $error("APB penable high without psel");

endmodule

// ==== logic/lbuf_top.sv ====
// Top level of the local buffer space manager
// Size table, allocation walker and release queue in a chain
// APB fills the table, the data side uses ready/acknowledge handshakes
`timescale 1ns/100ps

module lbuf_top (
	input  logic                          i_clk,
	input  logic                          i_arst_n,
	// APB to the size table
	input  logic                          i_psel,
	input  logic                          i_penable,
	input  logic                          i_pwrite,
	input  logic [3:0]                    i_paddr,
	input  logic [31:0]                   i_pwdata,
	output logic [31:0]                   o_prdata,
	output logic                          o_pready,
	// Allocation request
	input  logic                          i_alloc_rdy,
	output logic                          o_alloc_ack,
	input  logic [lbuf_pkg::ICFG_BW-1:0]  i_beg_id,
	input  logic [lbuf_pkg::ICFG_BW-1:0]  i_end_id,
	// Notice to the DMA
	output logic                          o_allocated_rdy,
	input  logic                          i_allocated_ack,
	// DMA write strobe
	input  logic                          i_we_dval,
	// Released addresses
	output logic                          o_linear_rdy,
	input  logic                          i_linear_ack,
	output logic [lbuf_pkg::LBW-1:0]      o_linear,
	// Free a table entry
	input  logic                          i_free_dval,
	input  logic [lbuf_pkg::ICFG_BW-1:0]  i_free_id
);

	import lbuf_pkg::*;

	// Table to walker
	lbuf_size_t [N_ICFG-1:0] sizes;

	// Walker to queue
	logic                    q_rdy;
	logic                    q_ack;
	lbuf_entry_t             q_entry;
	logic                    q_pop;

	lbuf_size_table u_size_table (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_sizes   (sizes)
	);

	lbuf_alloc_walk u_alloc_walk (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_sizes     (sizes),
		.i_alloc_rdy (i_alloc_rdy),
		.o_alloc_ack (o_alloc_ack),
		.i_beg_id    (i_beg_id),
		.i_end_id    (i_end_id),
		.o_q_rdy     (q_rdy),
		.i_q_ack     (q_ack),
		.o_q_entry   (q_entry),
		.i_q_pop     (q_pop),
		.i_free_dval (i_free_dval),
		.i_free_id   (i_free_id)
	);

	lbuf_release_queue u_release_queue (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_q_rdy         (q_rdy),
		.o_q_ack         (q_ack),
		.i_q_entry       (q_entry),
		.o_q_pop         (q_pop),
		.o_allocated_rdy (o_allocated_rdy),
		.i_allocated_ack (i_allocated_ack),
		.i_we_dval       (i_we_dval),
		.o_linear_rdy    (o_linear_rdy),
		.i_linear_ack    (i_linear_ack),
		.o_linear        (o_linear)
	);

endmodule
